// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_session_manager
FILELIST = vlog.f

.PHONY: sim clean

# build and run; a $fatal in the testbench gives a failing exit status
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== rtl/event_capture.sv ====
/*
 * First pipeline stage. Picks one of the connect, timeout and message
 * strobes per cycle (connect first, message last) and registers it.
 */
`timescale 1ns/1ps
`include "session_consts.svh"

module event_capture (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   connect_i,
	input  logic                   timeout_i,
	input  logic                   msg_valid_i,
	input  session_pkg::host_t     host_i,
	input  session_pkg::msg_type_t msg_type_i,
	input  session_pkg::validity_t validity_i,
	output logic                   ev_valid_o,
	output logic [1:0]             ev_kind_o,
	output session_pkg::host_t     ev_host_o,
	output session_pkg::msg_type_t ev_type_o,
	output session_pkg::validity_t ev_validity_o
);

	logic       any_ev;
	logic [1:0] kind_sel;

	assign any_ev = connect_i | timeout_i | msg_valid_i;

	// lower strobes of the same cycle are dropped
	always_comb begin
		if (connect_i)
			kind_sel = `EV_CONNECT;
		else if (timeout_i)
			kind_sel = `EV_TIMEOUT;
		else
			kind_sel = `EV_MESSAGE;
	end

	always_ff @(posedge clk) begin
		if (rst)
			ev_valid_o <= 1'b0;
		else
			ev_valid_o <= any_ev; // idle cycles clear it
	end

	always_ff @(posedge clk) begin
		if (any_ev) begin
			ev_kind_o     <= kind_sel;
			ev_host_o     <= host_i;
			ev_type_o     <= msg_type_i;
			ev_validity_o <= validity_i;
		end
	end

endmodule

// ==== rtl/host_table.sv ====
/*
 * Per-host configuration: initiator flag, target company id and its size.
 * Written through the config port, read one cycle after the address.
 */
`timescale 1ns/1ps
`include "session_consts.svh"

module host_table (
	input  logic                    clk,
	input  logic                    cfg_we_i,
	input  session_pkg::host_t      cfg_host_i,
	input  logic                    cfg_initiator_i,
	input  session_pkg::comp_id_t   cfg_comp_id_i,
	input  session_pkg::comp_size_t cfg_comp_size_i,
	input  session_pkg::host_t      rd_host_i,
	output logic                    initiator_o,
	output session_pkg::comp_id_t   comp_id_o,
	output session_pkg::comp_size_t comp_size_o
);

	import session_pkg::*;

	logic       initiator_mem [`NUM_HOSTS];
	comp_id_t   comp_id_mem   [`NUM_HOSTS];
	comp_size_t comp_size_mem [`NUM_HOSTS]; // significant bytes of the id

	always_ff @(posedge clk) begin
		if (cfg_we_i) begin
			initiator_mem[cfg_host_i] <= cfg_initiator_i;
			comp_id_mem[cfg_host_i]   <= cfg_comp_id_i;
			comp_size_mem[cfg_host_i] <= cfg_comp_size_i;
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		initiator_o <= initiator_mem[rd_host_i];
		comp_id_o   <= comp_id_mem[rd_host_i];
		comp_size_o <= comp_size_mem[rd_host_i];
	end

endmodule

// ==== rtl/session_consts.svh ====
/*
 * Widths and code points of the session layer.
 * Included by the package and by every module that decodes
 * message types, validity grades, session states or event kinds.
 */
`ifndef SESSION_CONSTS_SVH
`define SESSION_CONSTS_SVH

// field widths
`define HOST_ADDR_WIDTH   4
`define NUM_HOSTS         (1 << `HOST_ADDR_WIDTH)
`define COMP_ID_WIDTH     32
`define COMP_SIZE_WIDTH   4
`define STATE_WIDTH       3
`define MSG_TYPE_WIDTH    4
`define VALIDITY_WIDTH    4

// message types, shared by the receive side and create_message_o
`define MSG_HEARTBEAT     4'd1
`define MSG_RESEND_REQ    4'd2
`define MSG_GAP_FILL      4'd4
`define MSG_SEQ_RESET     4'd5
`define MSG_LOGOUT        4'd6
`define MSG_LOGON         4'd10

// validity grading from the receive processor
`define VAL_VALID         4'd0
`define VAL_SEQ_HIGH      4'd1 // gap detected
`define VAL_SEQ_LOW       4'd2 // fatal, below expected
`define VAL_GARBLED       4'd3
`define VAL_INVALID       4'd4

// session states
`define ST_DISCONNECTED   3'd0
`define ST_CONNECTED      3'd1 // acceptor waiting for logon
`define ST_LOGON_SENT     3'd2 // initiator waiting for logon
`define ST_NORMAL         3'd3
`define ST_SENT_HEARTBEAT 3'd4
`define ST_SENT_RESEND    3'd5
`define ST_RESEND_LOGOUT  3'd6 // resend pending, then logout
`define ST_LOGOUT_SENT    3'd7

// event kinds out of the capture stage
`define EV_CONNECT        2'd0
`define EV_TIMEOUT        2'd1
`define EV_MESSAGE        2'd2

`endif

// ==== rtl/session_decide.sv ====
/*
 * Final stage. Applies the session transition rules to the looked-up
 * event, writes the next state back to the state table in the same
 * cycle and registers the disconnect, ignore, sequence and send orders.
 */
`timescale 1ns/1ps
`include "session_consts.svh"

module session_decide (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    s2_valid_i,
	input  logic [1:0]              s2_kind_i,
	input  session_pkg::host_t      s2_host_i,
	input  session_pkg::msg_type_t  s2_type_i,
	input  session_pkg::validity_t  s2_validity_i,
	input  session_pkg::state_t     s2_state_i,
	input  logic                    s2_initiator_i,
	input  session_pkg::comp_id_t   s2_comp_id_i,
	input  session_pkg::comp_size_t s2_comp_size_i,
	output logic                    wr_en_o,
	output session_pkg::host_t      wr_host_o,
	output session_pkg::state_t     wr_state_o,
	output logic                    disconnect_o,
	output session_pkg::host_t      disconnect_host_o,
	output logic                    ignore_o,
	output logic                    seq_update_o,
	output session_pkg::host_t      seq_host_o,
	output logic                    initiate_msg_o,
	output session_pkg::msg_type_t  create_message_o,
	output session_pkg::comp_id_t   target_comp_id_o,
	output session_pkg::comp_size_t target_comp_size_o
);

	import session_pkg::*;

	state_t    nxt_state;
	msg_type_t send_code;
	logic      do_disc;
	logic      do_ignore;
	logic      do_seq;
	logic      do_send;
	logic      garbled;
	logic      seq_high;
	logic      valid_msg;
	logic      fatal;

	assign garbled   = (s2_validity_i == `VAL_GARBLED);
	assign seq_high  = (s2_validity_i == `VAL_SEQ_HIGH);
	assign valid_msg = (s2_validity_i == `VAL_VALID);
	assign fatal     = (s2_validity_i == `VAL_SEQ_LOW) || (s2_validity_i == `VAL_INVALID);

	always_comb begin
		nxt_state = s2_state_i;
		send_code = `MSG_HEARTBEAT;
		do_disc   = 1'b0;
		do_ignore = 1'b0;
		do_seq    = 1'b0;
		do_send   = 1'b0;

		case (s2_kind_i)
		`EV_CONNECT: begin
			if (s2_initiator_i) begin
				do_send   = 1'b1;
				send_code = `MSG_LOGON;
				nxt_state = `ST_LOGON_SENT;
			end else begin
				nxt_state = `ST_CONNECTED; // acceptor waits for the peer logon
			end
		end
		`EV_TIMEOUT: begin
			if (s2_state_i != `ST_DISCONNECTED) begin
				if (s2_state_i == `ST_LOGOUT_SENT || s2_state_i == `ST_SENT_HEARTBEAT ||
				    (s2_initiator_i && s2_state_i == `ST_LOGON_SENT)) begin
					do_disc = 1'b1; // peer silent too long
				end else begin
					do_send   = 1'b1;
					send_code = `MSG_HEARTBEAT;
					nxt_state = `ST_SENT_HEARTBEAT;
				end
			end
		end
		default: begin
			if (fatal) begin
				do_disc = 1'b1;
			end else begin
				case (s2_state_i)
				`ST_DISCONNECTED:
					do_ignore = 1'b1;
				`ST_CONNECTED, `ST_LOGON_SENT: begin
					if (s2_type_i == `MSG_LOGON && valid_msg) begin
						nxt_state = `ST_NORMAL;
						if (s2_state_i == `ST_CONNECTED) begin
							do_send   = 1'b1; // acceptor answers the logon
							send_code = `MSG_LOGON;
						end
					end else if (s2_type_i == `MSG_LOGON && seq_high) begin
						do_send   = 1'b1;
						send_code = `MSG_RESEND_REQ;
						nxt_state = `ST_SENT_RESEND;
					end else begin
						do_disc = 1'b1;
					end
				end
				`ST_LOGOUT_SENT: begin
					if (garbled)
						do_ignore = 1'b1;
					else
						do_disc = 1'b1;
				end
				`ST_NORMAL, `ST_SENT_HEARTBEAT: begin
					if (garbled) begin
						do_ignore = 1'b1;
					end else if (s2_type_i == `MSG_LOGOUT && seq_high) begin
						do_send   = 1'b1;
						send_code = `MSG_RESEND_REQ;
						nxt_state = `ST_RESEND_LOGOUT;
					end else if (s2_type_i == `MSG_LOGOUT && valid_msg) begin
						do_send   = 1'b1; // confirm logout, then drop
						send_code = `MSG_LOGOUT;
						do_disc   = 1'b1;
					end else if (seq_high) begin
						do_send   = 1'b1;
						send_code = `MSG_RESEND_REQ;
						nxt_state = `ST_SENT_RESEND;
					end else if (s2_type_i == `MSG_HEARTBEAT) begin
						do_send   = 1'b1;
						send_code = `MSG_HEARTBEAT;
						nxt_state = `ST_SENT_HEARTBEAT;
					end else begin
						nxt_state = `ST_NORMAL; // any traffic proves the peer alive
					end
				end
				default: begin
					// resend pending, state held until the gap is filled
					if (garbled) begin
						do_ignore = 1'b1;
					end else if (s2_type_i == `MSG_GAP_FILL || s2_type_i == `MSG_SEQ_RESET) begin
						do_seq = 1'b1;
					end else if (seq_high) begin
						do_send   = 1'b1;
						send_code = `MSG_RESEND_REQ;
					end
				end
				endcase
			end
		end
		endcase

		if (do_disc)
			nxt_state = `ST_DISCONNECTED;
	end

	// writeback lands on the same edge as the registered orders
	assign wr_en_o    = s2_valid_i;
	assign wr_host_o  = s2_host_i;
	assign wr_state_o = nxt_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			disconnect_o       <= 1'b0;
			disconnect_host_o  <= '0;
			ignore_o           <= 1'b0;
			seq_update_o       <= 1'b0;
			seq_host_o         <= '0;
			initiate_msg_o     <= 1'b0;
			create_message_o   <= '0;
			target_comp_id_o   <= '0;
			target_comp_size_o <= '0;
		end else begin
			disconnect_o      <= s2_valid_i & do_disc;
			disconnect_host_o <= (s2_valid_i && do_disc) ? s2_host_i : '0;
			ignore_o          <= s2_valid_i & do_ignore;
			seq_update_o      <= s2_valid_i & do_seq;
			seq_host_o        <= (s2_valid_i && do_seq) ? s2_host_i : '0;
			initiate_msg_o    <= s2_valid_i & do_send;
			if (s2_valid_i && do_send) begin
				create_message_o   <= send_code; // held for the message builder
				target_comp_id_o   <= s2_comp_id_i;
				target_comp_size_o <= s2_comp_size_i;
			end
		end
	end

endmodule

// ==== rtl/session_manager.sv ====
/*
 * Session layer top. Event capture, table lookup and decision run as a
 * three-stage pipeline; outputs follow each sampled event by three cycles.
 * Host configuration is loaded through the cfg_* write port.
 */
`timescale 1ns/1ps

module session_manager (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cfg_we_i,
	input  session_pkg::host_t      cfg_host_i,
	input  logic                    cfg_initiator_i,
	input  session_pkg::comp_id_t   cfg_comp_id_i,
	input  session_pkg::comp_size_t cfg_comp_size_i,
	input  logic                    connect_i,
	input  logic                    timeout_i,
	input  logic                    msg_valid_i,
	input  session_pkg::host_t      host_i,
	input  session_pkg::msg_type_t  msg_type_i,
	input  session_pkg::validity_t  validity_i,
	output logic                    disconnect_o,
	output session_pkg::host_t      disconnect_host_o,
	output logic                    ignore_o,
	output logic                    seq_update_o,
	output session_pkg::host_t      seq_host_o,
	output logic                    initiate_msg_o,
	output session_pkg::msg_type_t  create_message_o,
	output session_pkg::comp_id_t   target_comp_id_o,
	output session_pkg::comp_size_t target_comp_size_o
);

	import session_pkg::*;

	logic       ev_valid;
	logic [1:0] ev_kind;
	host_t      ev_host;
	msg_type_t  ev_type;
	validity_t  ev_validity;

	// stage-2 word, event half registered here, table half from the tables
	logic       s2_valid;
	logic [1:0] s2_kind;
	host_t      s2_host;
	msg_type_t  s2_type;
	validity_t  s2_validity;
	state_t     s2_state;
	logic       s2_initiator;
	comp_id_t   s2_comp_id;
	comp_size_t s2_comp_size;

	logic   wr_en;
	host_t  wr_host;
	state_t wr_state;

	event_capture u_event_capture (
		.clk           (clk),
		.rst           (rst),
		.connect_i     (connect_i),
		.timeout_i     (timeout_i),
		.msg_valid_i   (msg_valid_i),
		.host_i        (host_i),
		.msg_type_i    (msg_type_i),
		.validity_i    (validity_i),
		.ev_valid_o    (ev_valid),
		.ev_kind_o     (ev_kind),
		.ev_host_o     (ev_host),
		.ev_type_o     (ev_type),
		.ev_validity_o (ev_validity)
	);

	host_table u_host_table (
		.clk             (clk),
		.cfg_we_i        (cfg_we_i),
		.cfg_host_i      (cfg_host_i),
		.cfg_initiator_i (cfg_initiator_i),
		.cfg_comp_id_i   (cfg_comp_id_i),
		.cfg_comp_size_i (cfg_comp_size_i),
		.rd_host_i       (ev_host),
		.initiator_o     (s2_initiator),
		.comp_id_o       (s2_comp_id),
		.comp_size_o     (s2_comp_size)
	);

	session_state_table u_session_state_table (
		.clk        (clk),
		.rst        (rst),
		.rd_host_i  (ev_host),
		.wr_en_i    (wr_en),
		.wr_host_i  (wr_host),
		.wr_state_i (wr_state),
		.rd_state_o (s2_state)
	);

	// lookup stage, keeps the event in step with the table reads
	always_ff @(posedge clk) begin
		if (rst)
			s2_valid <= 1'b0;
		else
			s2_valid <= ev_valid;
	end

	always_ff @(posedge clk) begin
		s2_kind     <= ev_kind;
		s2_host     <= ev_host;
		s2_type     <= ev_type;
		s2_validity <= ev_validity;
	end

	session_decide u_session_decide (
		.clk                (clk),
		.rst                (rst),
		.s2_valid_i         (s2_valid),
		.s2_kind_i          (s2_kind),
		.s2_host_i          (s2_host),
		.s2_type_i          (s2_type),
		.s2_validity_i      (s2_validity),
		.s2_state_i         (s2_state),
		.s2_initiator_i     (s2_initiator),
		.s2_comp_id_i       (s2_comp_id),
		.s2_comp_size_i     (s2_comp_size),
		.wr_en_o            (wr_en),
		.wr_host_o          (wr_host),
		.wr_state_o         (wr_state),
		.disconnect_o       (disconnect_o),
		.disconnect_host_o  (disconnect_host_o),
		.ignore_o           (ignore_o),
		.seq_update_o       (seq_update_o),
		.seq_host_o         (seq_host_o),
		.initiate_msg_o     (initiate_msg_o),
		.create_message_o   (create_message_o),
		.target_comp_id_o   (target_comp_id_o),
		.target_comp_size_o (target_comp_size_o)
	);

endmodule

// ==== rtl/session_pkg.sv ====
/*
 * Width types of the session layer, sized from the constants header.
 * Used in port lists and in the testbench.
 */
package session_pkg;

	`include "session_consts.svh"

	typedef logic [`HOST_ADDR_WIDTH-1:0] host_t;
	typedef logic [`STATE_WIDTH-1:0] state_t;
	typedef logic [`MSG_TYPE_WIDTH-1:0] msg_type_t;
	typedef logic [`VALIDITY_WIDTH-1:0] validity_t;
	typedef logic [`COMP_ID_WIDTH-1:0] comp_id_t;
	typedef logic [`COMP_SIZE_WIDTH-1:0] comp_size_t;

endpackage

// ==== rtl/session_state_table.sv ====
/*
 * Session state per host. Reset returns every host to disconnected.
 * Synchronous read; a write to the host being read is forwarded.
 */
`timescale 1ns/1ps
`include "session_consts.svh"

module session_state_table (
	input  logic                clk,
	input  logic                rst,
	input  session_pkg::host_t  rd_host_i,
	input  logic                wr_en_i,
	input  session_pkg::host_t  wr_host_i,
	input  session_pkg::state_t wr_state_i,
	output session_pkg::state_t rd_state_o
);

	import session_pkg::*;

	state_t state_mem [`NUM_HOSTS];
	logic   bypass;

	// decide stage writes the host that lookup is reading right now
	assign bypass = wr_en_i && (wr_host_i == rd_host_i);

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_HOSTS; i++)
				state_mem[i] <= `ST_DISCONNECTED;
		end else if (wr_en_i) begin
			state_mem[wr_host_i] <= wr_state_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			rd_state_o <= `ST_DISCONNECTED;
		else if (bypass)
			rd_state_o <= wr_state_i;
		else
			rd_state_o <= state_mem[rd_host_i];
	end

endmodule

// ==== testbench/tb_session_manager.sv ====
/*
 * Directed testbench for the session layer top. A reference model of the
 * session rules predicts every output three cycles after each event.
 */
`timescale 1ns/1ps
`include "session_consts.svh"

module tb_session_manager;

	import session_pkg::*;

	localparam int CLK_PERIOD      = 8;
	localparam int RESET_CYCLES    = 5;
	localparam int CFG_EVENTS      = `NUM_HOSTS;
	localparam int DIRECTED_EVENTS = 45; // flush cycles included
	localparam int RANDOM_EVENTS   = 32;
	localparam int PLANNED_EVENTS  = CFG_EVENTS + DIRECTED_EVENTS + RANDOM_EVENTS + 3;
	localparam int WATCHDOG_NS     = (RESET_CYCLES + 6 * PLANNED_EVENTS + 40) * CLK_PERIOD;

	logic       clk;
	logic       rst;
	logic       cfg_we;
	host_t      cfg_host;
	logic       cfg_initiator;
	comp_id_t   cfg_comp_id;
	comp_size_t cfg_comp_size;
	logic       connect;
	logic       timeout;
	logic       msg_valid;
	host_t      host;
	msg_type_t  msg_type;
	validity_t  validity;
	logic       disconnect_o;
	host_t      disconnect_host_o;
	logic       ignore_o;
	logic       seq_update_o;
	host_t      seq_host_o;
	logic       initiate_msg_o;
	msg_type_t  create_message_o;
	comp_id_t   target_comp_id_o;
	comp_size_t target_comp_size_o;

	integer seed;

	// reference model of every host
	state_t     st_model   [`NUM_HOSTS];
	logic       init_model [`NUM_HOSTS];
	comp_id_t   id_model   [`NUM_HOSTS];
	comp_size_t size_model [`NUM_HOSTS];
	msg_type_t  last_code; // held outputs of the last send
	comp_id_t   last_id;
	comp_size_t last_size;
	state_t     nx_state;
	logic       nx_disc;
	logic       nx_ignore;
	logic       nx_seq;
	logic       nx_send;
	msg_type_t  nx_code;

	// {disc, disc_host, ignore, seq, seq_host, send, code, id, size}
	logic [51:0] exp_new;
	logic [51:0] exp_mid;
	logic [51:0] exp_old;

	session_manager u_session_manager (
		.clk                (clk),
		.rst                (rst),
		.cfg_we_i           (cfg_we),
		.cfg_host_i         (cfg_host),
		.cfg_initiator_i    (cfg_initiator),
		.cfg_comp_id_i      (cfg_comp_id),
		.cfg_comp_size_i    (cfg_comp_size),
		.connect_i          (connect),
		.timeout_i          (timeout),
		.msg_valid_i        (msg_valid),
		.host_i             (host),
		.msg_type_i         (msg_type),
		.validity_i         (validity),
		.disconnect_o       (disconnect_o),
		.disconnect_host_o  (disconnect_host_o),
		.ignore_o           (ignore_o),
		.seq_update_o       (seq_update_o),
		.seq_host_o         (seq_host_o),
		.initiate_msg_o     (initiate_msg_o),
		.create_message_o   (create_message_o),
		.target_comp_id_o   (target_comp_id_o),
		.target_comp_size_o (target_comp_size_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("Verification failed");
		$fatal(1);
	end

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			$display("Error: %s got 0x%0h expected 0x%0h", name, got, want);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	task automatic check_outputs(input logic [51:0] e);
		compare("disconnect_o", 32'(disconnect_o), 32'(e[51]));
		compare("disconnect_host_o", 32'(disconnect_host_o), 32'(e[50:47]));
		compare("ignore_o", 32'(ignore_o), 32'(e[46]));
		compare("seq_update_o", 32'(seq_update_o), 32'(e[45]));
		compare("seq_host_o", 32'(seq_host_o), 32'(e[44:41]));
		compare("initiate_msg_o", 32'(initiate_msg_o), 32'(e[40]));
		compare("create_message_o", 32'(create_message_o), 32'(e[39:36]));
		compare("target_comp_id_o", target_comp_id_o, e[35:4]);
		compare("target_comp_size_o", 32'(target_comp_size_o), 32'(e[3:0]));
	endtask

	task automatic order_msg(input msg_type_t code, input state_t next);
		nx_send  = 1'b1;
		nx_code  = code;
		nx_state = next;
	endtask

	task automatic drop_session();
		nx_disc  = 1'b1;
		nx_state = `ST_DISCONNECTED;
	endtask

	// session rules applied in arrival order
	task automatic model_event(input logic [1:0] kind, input host_t h, input msg_type_t mt,
	                           input validity_t v);
		state_t s;
		logic   lead;
		s        = st_model[h];
		lead     = init_model[h];
		nx_state = s;
		if (kind == `EV_CONNECT) begin
			if (lead)
				order_msg(`MSG_LOGON, `ST_LOGON_SENT);
			else
				nx_state = `ST_CONNECTED;
		end else if (kind == `EV_TIMEOUT) begin
			if (s == `ST_LOGOUT_SENT || s == `ST_SENT_HEARTBEAT)
				drop_session();
			else if (lead && s == `ST_LOGON_SENT)
				drop_session();
			else if (s != `ST_DISCONNECTED)
				order_msg(`MSG_HEARTBEAT, `ST_SENT_HEARTBEAT);
		end else if (v == `VAL_SEQ_LOW || v == `VAL_INVALID) begin
			drop_session();
		end else begin
			case (s)
			`ST_DISCONNECTED:
				nx_ignore = 1'b1;
			`ST_CONNECTED, `ST_LOGON_SENT: begin
				if (mt == `MSG_LOGON && v == `VAL_VALID) begin
					if (s == `ST_CONNECTED)
						order_msg(`MSG_LOGON, `ST_NORMAL);
					else
						nx_state = `ST_NORMAL;
				end else if (mt == `MSG_LOGON && v == `VAL_SEQ_HIGH) begin
					order_msg(`MSG_RESEND_REQ, `ST_SENT_RESEND);
				end else begin
					drop_session();
				end
			end
			`ST_LOGOUT_SENT: begin
				if (v == `VAL_GARBLED)
					nx_ignore = 1'b1;
				else
					drop_session();
			end
			`ST_NORMAL, `ST_SENT_HEARTBEAT: begin
				if (v == `VAL_GARBLED) begin
					nx_ignore = 1'b1;
				end else if (mt == `MSG_LOGOUT && v == `VAL_SEQ_HIGH) begin
					order_msg(`MSG_RESEND_REQ, `ST_RESEND_LOGOUT);
				end else if (mt == `MSG_LOGOUT && v == `VAL_VALID) begin
					order_msg(`MSG_LOGOUT, `ST_NORMAL);
					drop_session(); // logout answered and the session dropped
				end else if (v == `VAL_SEQ_HIGH) begin
					order_msg(`MSG_RESEND_REQ, `ST_SENT_RESEND);
				end else if (mt == `MSG_HEARTBEAT) begin
					order_msg(`MSG_HEARTBEAT, `ST_SENT_HEARTBEAT);
				end else begin
					nx_state = `ST_NORMAL;
				end
			end
			default: begin
				// both resend states keep their state
				if (v == `VAL_GARBLED)
					nx_ignore = 1'b1;
				else if (mt == `MSG_GAP_FILL || mt == `MSG_SEQ_RESET)
					nx_seq = 1'b1;
				else if (v == `VAL_SEQ_HIGH)
					order_msg(`MSG_RESEND_REQ, s);
			end
			endcase
		end
		st_model[h] = nx_state;
		if (nx_send) begin
			last_code = nx_code;
			last_id   = id_model[h];
			last_size = size_model[h];
		end
	endtask

	// checks what is due now and then drives the next strobes
	task automatic step(input logic c, input logic t, input logic m, input host_t h,
	                    input msg_type_t mt, input validity_t v);
		@(negedge clk);
		check_outputs(exp_old);
		exp_old   = exp_mid;
		exp_mid   = exp_new;
		cfg_we    = 1'b0;
		connect   = c;
		timeout   = t;
		msg_valid = m;
		host      = h;
		msg_type  = mt;
		validity  = v;
		nx_disc   = 1'b0;
		nx_ignore = 1'b0;
		nx_seq    = 1'b0;
		nx_send   = 1'b0;
		nx_code   = '0;
		if (c)
			model_event(`EV_CONNECT, h, mt, v); // lower strobes dropped
		else if (t)
			model_event(`EV_TIMEOUT, h, mt, v);
		else if (m)
			model_event(`EV_MESSAGE, h, mt, v);
		exp_new = {nx_disc, nx_disc ? h : 4'h0, nx_ignore, nx_seq, nx_seq ? h : 4'h0,
		           nx_send, last_code, last_id, last_size};
	endtask

	task automatic idle();
		step(1'b0, 1'b0, 1'b0, 4'h0, 4'h0, 4'h0);
	endtask

	task automatic drain();
		repeat (3) idle(); // pipeline depth
	endtask

	task automatic connect_host(input host_t h);
		step(1'b1, 1'b0, 1'b0, h, 4'h0, 4'h0);
	endtask

	task automatic timeout_host(input host_t h);
		step(1'b0, 1'b1, 1'b0, h, 4'h0, 4'h0);
	endtask

	task automatic receive_msg(input host_t h, input msg_type_t mt, input validity_t v);
		step(1'b0, 1'b0, 1'b1, h, mt, v);
	endtask

	task automatic configure_host(input host_t h, input logic lead);
		logic [31:0] rnd;
		idle();
		rnd           = $random(seed);
		cfg_we        = 1'b1;
		cfg_host      = h;
		cfg_initiator = lead;
		cfg_comp_id   = $random(seed);
		cfg_comp_size = rnd[3:0];
		init_model[h] = lead;
		id_model[h]   = cfg_comp_id;
		size_model[h] = cfg_comp_size;
	endtask

	function automatic msg_type_t pick_type(input logic [2:0] sel);
		case (sel)
		3'd0: return `MSG_HEARTBEAT;
		3'd1: return `MSG_RESEND_REQ;
		3'd2: return `MSG_GAP_FILL;
		3'd3: return `MSG_SEQ_RESET;
		3'd4: return `MSG_LOGOUT;
		3'd6: return 4'd0; // application message
		default: return `MSG_LOGON;
		endcase
	endfunction

	task automatic initiator_logon();
		connect_host(4'd1);
		receive_msg(4'd1, `MSG_LOGON, `VAL_VALID);
		drain();
	endtask

	task automatic acceptor_logon();
		connect_host(4'd2);
		receive_msg(4'd2, `MSG_LOGON, `VAL_VALID);
		receive_msg(4'd2, `MSG_HEARTBEAT, `VAL_VALID);
		drain();
	endtask

	task automatic seq_low_disconnect();
		receive_msg(4'd2, `MSG_HEARTBEAT, `VAL_SEQ_LOW);
		receive_msg(4'd2, `MSG_LOGON, `VAL_VALID); // host already gone
		drain();
	endtask

	task automatic heartbeat_timeouts();
		connect_host(4'd3);
		receive_msg(4'd3, `MSG_LOGON, `VAL_VALID);
		timeout_host(4'd3);
		timeout_host(4'd3);
		timeout_host(4'd3);
		drain();
	endtask

	// upper hosts so that the top host bit reaches the outputs
	task automatic resend_and_logout();
		connect_host(4'd12);
		receive_msg(4'd12, `MSG_LOGON, `VAL_VALID);
		receive_msg(4'd12, `MSG_HEARTBEAT, `VAL_SEQ_HIGH);
		receive_msg(4'd12, `MSG_GAP_FILL, `VAL_VALID);
		receive_msg(4'd1, `MSG_LOGOUT, `VAL_SEQ_HIGH);
		connect_host(4'd13);
		receive_msg(4'd13, `MSG_LOGON, `VAL_VALID);
		receive_msg(4'd13, `MSG_LOGOUT, `VAL_VALID);
		drain();
	endtask

	task automatic bypass_and_priority();
		step(1'b1, 1'b0, 1'b1, 4'd2, `MSG_LOGON, `VAL_VALID); // connect wins
		receive_msg(4'd2, `MSG_LOGON, `VAL_VALID);
		receive_msg(4'd2, `MSG_HEARTBEAT, `VAL_VALID);
		receive_msg(4'd2, 4'd0, `VAL_VALID);
		timeout_host(4'd2);
		timeout_host(4'd2);
		step(1'b0, 1'b1, 1'b1, 4'd3, `MSG_LOGON, `VAL_VALID);
		drain();
	endtask

	task automatic random_burst();
		logic [31:0] rnd;
		validity_t   v;
		repeat (RANDOM_EVENTS) begin
			rnd = $random(seed);
			v   = (rnd[14:12] > 3'd4) ? `VAL_VALID : {1'b0, rnd[14:12]};
			step(rnd[17:16] == 2'd0, rnd[17:16] == 2'd1, rnd[17] | rnd[18],
			     rnd[3:0], pick_type(rnd[10:8]), v);
		end
		drain();
	endtask

	initial begin
		seed          = 81;
		rst           = 1'b1;
		cfg_we        = 1'b0;
		cfg_host      = '0;
		cfg_initiator = 1'b0;
		cfg_comp_id   = '0;
		cfg_comp_size = '0;
		connect       = 1'b0;
		timeout       = 1'b0;
		msg_valid     = 1'b0;
		host          = '0;
		msg_type      = '0;
		validity      = '0;
		st_model      = '{default: `ST_DISCONNECTED};
		last_code     = '0;
		last_id       = '0;
		last_size     = '0;
		exp_new       = '0;
		exp_mid       = '0;
		exp_old       = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < CFG_EVENTS; i++)
			configure_host(host_t'(i), i[0]); // odd hosts initiate
		initiator_logon();
		acceptor_logon();
		seq_low_disconnect();
		heartbeat_timeouts();
		resend_and_logout();
		bypass_and_priority();
		random_burst();
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/session_pkg.sv
rtl/event_capture.sv
rtl/host_table.sv
rtl/session_state_table.sv
rtl/session_decide.sv
rtl/session_manager.sv
testbench/tb_session_manager.sv
